// File: run_sim.sh
#!/usr/bin/env bash
# Build the stream tap testbench with Verilator and run it.
# The run counts as passed only if the log holds the pass line.
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal -f sources.f \
    --top-module tb_stream_tap -o tb_stream_tap \
    && ./obj_dir/tb_stream_tap | tee sim.log \
    || { echo "build or simulation run failed"; exit 1; }

grep -q "ALL TESTS PASSED" sim.log && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }

// File: sources.f
src/tap_pkg.sv
src/tap_frame_ctrl.sv
src/tap_out_buffer.sv
src/tap_stats.sv
src/stream_tap.sv
verif/tb_stream_tap.sv

// File: src/stream_tap.sv
/*
 * Passive AXI4-Stream frame monitor, 64-bit
 * Mirrors every accepted beat of the observed link onto a separate
 * monitor stream. Monitor back-pressure never reaches the observed
 * link; frames are dropped or truncated instead and counted.
 */

`timescale 1ns/1ps

module stream_tap (
    input  logic                            clk,
    input  logic                            rst,

    // observed link, read only
    input  logic [tap_pkg::data_width-1:0]  obs_tdata,
    input  logic [tap_pkg::keep_width-1:0]  obs_tkeep,
    input  logic                            obs_tvalid,
    input  logic                            obs_tready,
    input  logic                            obs_tlast,
    input  logic                            obs_tuser,

    // monitor stream
    output logic [tap_pkg::data_width-1:0]  mon_tdata,
    output logic [tap_pkg::keep_width-1:0]  mon_tkeep,
    output logic                            mon_tvalid,
    input  logic                            mon_tready,
    output logic                            mon_tlast,
    output logic                            mon_tuser,

    output logic [tap_pkg::count_width-1:0] count_ok,
    output logic [tap_pkg::count_width-1:0] count_trunc,
    output logic [tap_pkg::count_width-1:0] count_drop
);

    logic [tap_pkg::data_width-1:0] beat_data;
    logic [tap_pkg::keep_width-1:0] beat_keep;
    logic                           beat_valid;
    logic                           beat_last;
    logic                           beat_user;
    logic                           buf_ready;

    logic ev_ok;
    logic ev_trunc;
    logic ev_drop;

    tap_frame_ctrl i_ctrl (
        .clk, .rst,
        .obs_tdata, .obs_tkeep, .obs_tvalid, .obs_tready, .obs_tlast, .obs_tuser,
        .buf_ready,
        .beat_data, .beat_keep, .beat_valid, .beat_last, .beat_user,
        .ev_ok, .ev_trunc, .ev_drop
    );

    tap_out_buffer i_buf (
        .clk, .rst,
        .beat_data, .beat_keep, .beat_valid, .beat_last, .beat_user,
        .buf_ready,
        .mon_tdata, .mon_tkeep, .mon_tvalid, .mon_tready, .mon_tlast, .mon_tuser
    );

    tap_stats i_stats (
        .clk, .rst,
        .ev_ok, .ev_trunc, .ev_drop,
        .count_ok, .count_trunc, .count_drop
    );

endmodule

// File: src/tap_frame_ctrl.sv
/*
 * Stream tap frame-decision controller
 * Watches accepted beats on the observed link and decides per frame
 * whether to forward it, cut it short with a marker or drop it whole.
 * Forwarded beats are strobed combinationally to the output buffer,
 * and each frame outcome is reported as a one-cycle event pulse.
 */

`timescale 1ns/1ps

module tap_frame_ctrl (
    input  logic                           clk,
    input  logic                           rst,

    input  logic [tap_pkg::data_width-1:0] obs_tdata,
    input  logic [tap_pkg::keep_width-1:0] obs_tkeep,
    input  logic                           obs_tvalid,
    input  logic                           obs_tready,
    input  logic                           obs_tlast,
    input  logic                           obs_tuser,

    input  logic                           buf_ready,

    output logic [tap_pkg::data_width-1:0] beat_data,
    output logic [tap_pkg::keep_width-1:0] beat_keep,
    output logic                           beat_valid,
    output logic                           beat_last,
    output logic                           beat_user,

    output logic                           ev_ok,
    output logic                           ev_trunc,
    output logic                           ev_drop
);

    tap_pkg::tap_state_e state;
    tap_pkg::tap_state_e state_next;

    // set between an accepted first beat and the accepted last beat
    logic in_frame;
    logic in_frame_next;

    logic obs_beat;
    logic fwd;
    logic mark;
    logic drop;

    assign obs_beat = obs_tvalid & obs_tready;

    always_comb begin
        state_next    = state;
        in_frame_next = in_frame;
        fwd           = 1'b0;
        mark          = 1'b0;
        drop          = 1'b0;

        if (obs_beat) begin
            in_frame_next = ~obs_tlast;
        end

        case (state)
            tap_pkg::st_idle: begin
                if (obs_beat) begin
                    if (buf_ready) begin
                        fwd        = 1'b1;
                        state_next = obs_tlast ? tap_pkg::st_idle : tap_pkg::st_transfer;
                    end else begin
                        // no room at frame start so the whole frame is dropped
                        drop       = 1'b1;
                        state_next = obs_tlast ? tap_pkg::st_idle : tap_pkg::st_wait;
                    end
                end
            end
            tap_pkg::st_transfer: begin
                if (obs_beat) begin
                    if (buf_ready) begin
                        fwd        = 1'b1;
                        state_next = obs_tlast ? tap_pkg::st_idle : tap_pkg::st_transfer;
                    end else begin
                        state_next = tap_pkg::st_truncate;
                    end
                end
            end
            tap_pkg::st_truncate: begin
                // beats seen here are discarded and tracked only by the frame flag
                if (obs_beat && !in_frame) begin
                    // marker still pending so the new frame cannot be mirrored
                    drop = 1'b1;
                end else if (buf_ready) begin
                    mark       = 1'b1;
                    state_next = in_frame_next ? tap_pkg::st_wait : tap_pkg::st_idle;
                end
            end
            tap_pkg::st_wait: begin
                if (obs_beat && obs_tlast) begin
                    state_next = tap_pkg::st_idle;
                end
            end
            default: begin
                state_next = tap_pkg::st_idle;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= tap_pkg::st_idle;
            in_frame <= 1'b0;
        end else begin
            state    <= state_next;
            in_frame <= in_frame_next;
        end
    end

    // marker replaces the observed payload on the buffer strobe
    assign beat_valid = fwd | mark;
    assign beat_data  = mark ? tap_pkg::trunc_data : obs_tdata;
    assign beat_keep  = mark ? tap_pkg::trunc_keep : obs_tkeep;
    assign beat_last  = mark | obs_tlast;
    assign beat_user  = mark | obs_tuser;

    assign ev_ok    = fwd & obs_tlast;
    assign ev_trunc = mark;
    assign ev_drop  = drop;

    // buffer only guarantees storage while its ready is high
    a_strobe_needs_ready: assert property (
        @(posedge clk) disable iff (rst) beat_valid |-> buf_ready
    );

    a_one_event: assert property (
        @(posedge clk) disable iff (rst) $onehot0({ev_ok, ev_trunc, ev_drop})
    );

endmodule

// File: src/tap_out_buffer.sv
/*
 * Stream tap output buffer
 * Output register plus one temporary register, so the ready
 * returned to the controller can be registered a cycle ahead
 * without losing a beat when the monitor port stalls.
 */

`timescale 1ns/1ps

module tap_out_buffer (
    input  logic                           clk,
    input  logic                           rst,

    input  logic [tap_pkg::data_width-1:0] beat_data,
    input  logic [tap_pkg::keep_width-1:0] beat_keep,
    input  logic                           beat_valid,
    input  logic                           beat_last,
    input  logic                           beat_user,
    output logic                           buf_ready,

    output logic [tap_pkg::data_width-1:0] mon_tdata,
    output logic [tap_pkg::keep_width-1:0] mon_tkeep,
    output logic                           mon_tvalid,
    input  logic                           mon_tready,
    output logic                           mon_tlast,
    output logic                           mon_tuser
);

    logic [tap_pkg::data_width-1:0] tmp_data;
    logic [tap_pkg::keep_width-1:0] tmp_keep;
    logic                           tmp_valid;
    logic                           tmp_last;
    logic                           tmp_user;

    logic out_valid_next;
    logic tmp_valid_next;
    logic ready_early;

    logic in_to_out;
    logic in_to_tmp;
    logic tmp_to_out;

    // temp cannot fill next cycle if the monitor drains or the output is free
    assign ready_early = mon_tready | (~tmp_valid & (~mon_tvalid | ~beat_valid));

    always_comb begin
        out_valid_next = mon_tvalid;
        tmp_valid_next = tmp_valid;
        in_to_out      = 1'b0;
        in_to_tmp      = 1'b0;
        tmp_to_out     = 1'b0;

        if (buf_ready) begin
            if (mon_tready || !mon_tvalid) begin
                out_valid_next = beat_valid;
                in_to_out      = 1'b1;
            end else begin
                // output stalled, park incoming beat
                tmp_valid_next = beat_valid;
                in_to_tmp      = 1'b1;
            end
        end else if (mon_tready) begin
            out_valid_next = tmp_valid;
            tmp_valid_next = 1'b0;
            tmp_to_out     = 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            mon_tvalid <= 1'b0;
            tmp_valid  <= 1'b0;
            buf_ready  <= 1'b0;
        end else begin
            mon_tvalid <= out_valid_next;
            tmp_valid  <= tmp_valid_next;
            buf_ready  <= ready_early;
        end
    end

    // payload registers
    always_ff @(posedge clk) begin
        if (in_to_out) begin
            mon_tdata <= beat_data;
            mon_tkeep <= beat_keep;
            mon_tlast <= beat_last;
            mon_tuser <= beat_user;
        end else if (tmp_to_out) begin
            mon_tdata <= tmp_data;
            mon_tkeep <= tmp_keep;
            mon_tlast <= tmp_last;
            mon_tuser <= tmp_user;
        end

        if (in_to_tmp) begin
            tmp_data <= beat_data;
            tmp_keep <= beat_keep;
            tmp_last <= beat_last;
            tmp_user <= beat_user;
        end
    end

    a_stall_stable: assert property (
        @(posedge clk) disable iff (rst)
        (mon_tvalid && !mon_tready) |=>
            (mon_tvalid && $stable({mon_tdata, mon_tkeep, mon_tlast, mon_tuser}))
    );

endmodule

// File: src/tap_pkg.sv
/*
 * Stream tap shared definitions
 * Bus widths, counter width, truncation marker constants and the
 * state encoding of the frame-decision controller.
 */

package tap_pkg;

    // observed and monitor stream widths
    localparam int data_width = 64;
    localparam int keep_width = data_width / 8;

    // per-class frame counters, wrap on overflow
    localparam int count_width = 16;

    // truncation marker, one byte of zero data, last and user set
    localparam logic [data_width-1:0] trunc_data = '0;
    localparam logic [keep_width-1:0] trunc_keep = {{(keep_width-1){1'b0}}, 1'b1};

    // frame-decision states
    typedef enum logic [1:0] {
        // between frames
        st_idle,
        // mirroring a frame
        st_transfer,
        // monitor path blocked mid-frame, marker pending
        st_truncate,
        // discarding the rest of a frame
        st_wait
    } tap_state_e;

endpackage

// File: src/tap_stats.sv
/*
 * Stream tap frame statistics
 * Counts frames mirrored whole, truncated and dropped, one
 * wrapping counter per class, fed by single-cycle event pulses.
 */

`timescale 1ns/1ps

module tap_stats (
    input  logic                            clk,
    input  logic                            rst,

    input  logic                            ev_ok,
    input  logic                            ev_trunc,
    input  logic                            ev_drop,

    output logic [tap_pkg::count_width-1:0] count_ok,
    output logic [tap_pkg::count_width-1:0] count_trunc,
    output logic [tap_pkg::count_width-1:0] count_drop
);

    // frames mirrored whole
    always_ff @(posedge clk) begin
        if (rst) begin
            count_ok <= '0;
        end else if (ev_ok) begin
            count_ok <= count_ok + 1'b1;
        end
    end

    // frames closed with the marker
    always_ff @(posedge clk) begin
        if (rst) begin
            count_trunc <= '0;
        end else if (ev_trunc) begin
            count_trunc <= count_trunc + 1'b1;
        end
    end

    // frames dropped at start
    always_ff @(posedge clk) begin
        if (rst) begin
            count_drop <= '0;
        end else if (ev_drop) begin
            count_drop <= count_drop + 1'b1;
        end
    end

    // each frame ends in exactly one class and never two in one cycle
    a_single_event: assert property (
        @(posedge clk) disable iff (rst) $onehot0({ev_ok, ev_trunc, ev_drop})
    );

endmodule

// File: verif/tb_stream_tap.sv
/*
 * Stream tap testbench
 * Drives frames onto the observed link, collects the monitor stream,
 * classifies every monitor frame against the observed frames and
 * checks the frame counters, under several monitor ready patterns.
 */

`timescale 1ns/1ps

module tb_stream_tap;

    localparam int total_beats = 1200;

    logic clk = 1'b0;
    logic rst;
    logic [tap_pkg::data_width-1:0]  obs_tdata;
    logic [tap_pkg::keep_width-1:0]  obs_tkeep;
    logic obs_tvalid, obs_tready, obs_tlast, obs_tuser;
    logic [tap_pkg::data_width-1:0]  mon_tdata;
    logic [tap_pkg::keep_width-1:0]  mon_tkeep;
    logic mon_tvalid, mon_tready, mon_tlast, mon_tuser;
    logic [tap_pkg::count_width-1:0] count_ok, count_trunc, count_drop;

    // accepted beats kept flat with per-frame start and length
    logic [tap_pkg::data_width-1:0] obs_data[$], mon_data[$];
    logic [tap_pkg::keep_width-1:0] obs_keep[$], mon_keep[$];
    logic obs_user[$], obs_last[$], mon_user[$], mon_last[$];
    int obs_fstart[$], obs_flen[$], mon_fstart[$], mon_flen[$];
    int obs_cur, mon_cur;

    logic [tap_pkg::count_width-1:0] exp_ok, exp_trunc, exp_drop;
    int errors = 0;
    int tests_failed = 0;
    int test_base;
    int ready_mode;
    logic cmp_req = 1'b0;
    logic cmp_exact;

    stream_tap i_dut (.*);

    always #4 clk = ~clk;

    // 0 holds ready low, 1 high, 2 random
    always @(posedge clk) begin
        case (ready_mode)
            0: mon_tready <= 1'b0;
            1: mon_tready <= 1'b1;
            default: mon_tready <= rand_bit();
        endcase
    end

    always @(posedge clk) begin
        if (!rst && obs_tvalid && obs_tready) begin
            obs_data.push_back(obs_tdata);
            obs_keep.push_back(obs_tkeep);
            obs_user.push_back(obs_tuser);
            obs_last.push_back(obs_tlast);
            obs_cur++;
            if (obs_tlast) begin
                obs_fstart.push_back(obs_data.size() - obs_cur);
                obs_flen.push_back(obs_cur);
                obs_cur = 0;
            end
        end
    end

    always @(posedge clk) begin
        if (!rst && mon_tvalid && mon_tready) begin
            mon_data.push_back(mon_tdata);
            mon_keep.push_back(mon_tkeep);
            mon_user.push_back(mon_tuser);
            mon_last.push_back(mon_tlast);
            mon_cur++;
            if (mon_tlast) begin
                mon_fstart.push_back(mon_data.size() - mon_cur);
                mon_flen.push_back(mon_cur);
                mon_cur = 0;
            end
        end
    end

    function automatic logic rand_bit();
        logic [31:0] r;
        r = $urandom;
        return r[0];
    endfunction

    function automatic logic [tap_pkg::keep_width-1:0] rand_keep();
        logic [31:0] r;
        r = $urandom;
        return r[tap_pkg::keep_width-1:0];
    endfunction

    function automatic logic beat_equal(int o, int m);
        return obs_data[o] == mon_data[m] && obs_keep[o] == mon_keep[m]
            && obs_user[o] == mon_user[m] && obs_last[o] == mon_last[m];
    endfunction

    // 0 exact copy, 1 prefix plus marker, 2 no match
    function automatic int classify_frame(int of, int mf);
        int os, ms, ol, ml, b;
        logic same;
        os = obs_fstart[of];
        ol = obs_flen[of];
        ms = mon_fstart[mf];
        ml = mon_flen[mf];
        same = 1'b1;
        if (ml == ol) begin
            for (b = 0; b < ml; b++) same &= beat_equal(os + b, ms + b);
            if (same) return 0;
        end
        if (ml < 2 || ml - 1 >= ol) return 2;
        same = 1'b1;
        for (b = 0; b < ml - 1; b++) same &= beat_equal(os + b, ms + b);
        // marker carries zero data and only the lowest keep bit
        same &= mon_data[ms + ml - 1] == '0 && mon_keep[ms + ml - 1] == 1;
        same &= mon_user[ms + ml - 1] && mon_last[ms + ml - 1];
        return same ? 1 : 2;
    endfunction

    function automatic int frames_counted();
        return int'(count_ok) + int'(count_trunc) + int'(count_drop);
    endfunction

    task automatic check_beat(input int frame, input int beat,
                              input logic [tap_pkg::data_width-1:0] exp_data, got_data,
                              input logic [tap_pkg::keep_width-1:0] exp_keep, got_keep,
                              input logic exp_user, got_user, exp_last, got_last);
        if (exp_data !== got_data || exp_keep !== got_keep
            || exp_user !== got_user || exp_last !== got_last) begin
            $display("** Error at %0t: frame %0d beat %0d got %h/%h/%b/%b exp %h/%h/%b/%b",
                     $time, frame, beat, got_data, got_keep, got_user, got_last,
                     exp_data, exp_keep, exp_user, exp_last);
            errors++;
        end
    endtask

    task automatic check_count(input string name,
                               input logic [tap_pkg::count_width-1:0] exp_val, got_val);
        if (exp_val !== got_val) begin
            $display("** Error at %0t: %s is %0d, expected %0d", $time, name, got_val, exp_val);
            errors++;
        end
    endtask

    // matches monitor frames to observed frames in order
    always begin
        int o, m, b, r, n_ok, n_trunc, n_drop;
        wait (cmp_req);
        o = 0;
        n_ok = 0;
        n_trunc = 0;
        n_drop = 0;
        if (mon_flen.size() > obs_flen.size()) begin
            $display("more monitor frames (%0d) than observed frames (%0d)",
                     mon_flen.size(), obs_flen.size());
            errors++;
        end
        for (m = 0; m < mon_flen.size(); m++) begin
            if (cmp_exact) begin
                if (o >= obs_flen.size() || mon_flen[m] != obs_flen[o]) begin
                    $display("** Error at %0t: monitor frame %0d has the wrong length", $time, m);
                    errors++;
                end else begin
                    for (b = 0; b < mon_flen[m]; b++) begin
                        check_beat(m, b, obs_data[obs_fstart[o] + b], mon_data[mon_fstart[m] + b],
                                   obs_keep[obs_fstart[o] + b], mon_keep[mon_fstart[m] + b],
                                   obs_user[obs_fstart[o] + b], mon_user[mon_fstart[m] + b],
                                   obs_last[obs_fstart[o] + b], mon_last[mon_fstart[m] + b]);
                    end
                end
                n_ok++;
                o++;
            end else begin
                r = 2;
                while (o < obs_flen.size() && r == 2) begin
                    r = classify_frame(o, m);
                    if (r == 2) begin
                        n_drop++;
                        o++;
                    end
                end
                if (r == 2) begin
                    $display("monitor frame %0d matches no observed frame", m);
                    errors++;
                end else begin
                    if (r == 0) n_ok++;
                    else n_trunc++;
                    o++;
                end
            end
        end
        if (o < obs_flen.size()) n_drop += obs_flen.size() - o;
        if (cmp_exact && n_drop != 0) begin
            $display("%0d observed frames never reached the monitor port", n_drop);
            errors++;
        end
        exp_ok = exp_ok + n_ok[tap_pkg::count_width-1:0];
        exp_trunc = exp_trunc + n_trunc[tap_pkg::count_width-1:0];
        exp_drop = exp_drop + n_drop[tap_pkg::count_width-1:0];
        cmp_req = 1'b0;
    end

    task automatic clear_queues();
        obs_data.delete();
        obs_keep.delete();
        obs_user.delete();
        obs_last.delete();
        mon_data.delete();
        mon_keep.delete();
        mon_user.delete();
        mon_last.delete();
        obs_fstart.delete();
        obs_flen.delete();
        mon_fstart.delete();
        mon_flen.delete();
        obs_cur = 0;
        mon_cur = 0;
    endtask

    task automatic send_frame(input int len, input logic stalls);
        int b, n;
        for (b = 0; b < len; b++) begin
            n = stalls ? $urandom % 3 : 0;
            // valid without ready, never an accepted beat
            repeat (n) begin
                @(posedge clk);
                obs_tvalid <= 1'b1;
                obs_tready <= 1'b0;
                obs_tdata  <= {$urandom, $urandom};
                obs_tlast  <= rand_bit();
            end
            @(posedge clk);
            obs_tdata  <= {$urandom, $urandom};
            obs_tkeep  <= rand_keep();
            obs_tuser  <= rand_bit();
            obs_tlast  <= (b == len - 1);
            obs_tvalid <= 1'b1;
            obs_tready <= 1'b1;
        end
        @(posedge clk);
        obs_tvalid <= 1'b0;
        obs_tready <= rand_bit();
    endtask

    task automatic finish_test(input int num, input string name, input logic exact);
        int idle, cycles, base;
        base = int'(exp_ok) + int'(exp_trunc) + int'(exp_drop);
        @(negedge clk);
        ready_mode = 1;
        idle = 0;
        cycles = 0;
        while (idle < 4 && cycles < 400) begin
            @(negedge clk);
            cycles++;
            if (!mon_tvalid && frames_counted() == base + obs_flen.size()) idle++;
            else idle = 0;
        end
        if (idle < 4) begin
            $display("monitor port did not drain, controller in %s",
                     i_dut.i_ctrl.state.name());
            errors++;
        end
        cmp_exact = exact;
        cmp_req = 1'b1;
        wait (!cmp_req);
        check_count("count_ok", exp_ok, count_ok);
        check_count("count_trunc", exp_trunc, count_trunc);
        check_count("count_drop", exp_drop, count_drop);
        if (errors != test_base) tests_failed++;
        $display("test %0d %s: %s", num, name, errors == test_base ? "pass" : "FAIL");
    endtask

    initial begin
        #(total_beats * 20 * 8);
        $display("watchdog expired, run took too long, controller in %s",
                 i_dut.i_ctrl.state.name());
        $display("SOME TESTS FAILED");
        $finish;
    end

    initial begin
        void'($urandom(91));
        rst = 1'b1;
        obs_tdata = '0;
        obs_tkeep = '0;
        obs_tvalid = 1'b0;
        obs_tready = 1'b0;
        obs_tlast = 1'b0;
        obs_tuser = 1'b0;
        mon_tready = 1'b0;
        ready_mode = 1;
        exp_ok = '0;
        exp_trunc = '0;
        exp_drop = '0;
        clear_queues();
        repeat (4) @(posedge clk);
        rst <= 1'b0;
        repeat (3) @(posedge clk);

        test_base = errors;
        for (int i = 0; i < 20; i++) send_frame(1 + $urandom % 16, 1'b0);
        finish_test(1, "exact mirror", 1'b1);

        clear_queues();
        test_base = errors;
        for (int i = 0; i < 6; i++) send_frame(1 + $urandom % 16, 1'b1);
        finish_test(2, "stalled observed beats", 1'b1);

        clear_queues();
        test_base = errors;
        ready_mode = 0;
        for (int i = 0; i < 6; i++) send_frame(1 + $urandom % 16, 1'b0);
        finish_test(3, "monitor held off", 1'b0);

        clear_queues();
        test_base = errors;
        ready_mode = 2;
        for (int i = 0; i < 40; i++) send_frame(1 + $urandom % 16, 1'b0);
        finish_test(4, "random monitor ready", 1'b0);

        // reset in the middle of a frame while the monitor port stalls
        test_base = errors;
        ready_mode = 0;
        for (int b = 0; b < 4; b++) begin
            @(posedge clk);
            obs_tdata  <= {$urandom, $urandom};
            obs_tkeep  <= rand_keep();
            obs_tuser  <= rand_bit();
            obs_tlast  <= 1'b0;
            obs_tvalid <= 1'b1;
            obs_tready <= 1'b1;
        end
        @(posedge clk);
        rst <= 1'b1;
        obs_tvalid <= 1'b0;
        repeat (3) @(posedge clk);
        @(negedge clk);
        if (mon_tvalid !== 1'b0) begin
            $display("** Error at %0t: mon_tvalid high during reset", $time);
            errors++;
        end
        exp_ok = '0;
        exp_trunc = '0;
        exp_drop = '0;
        check_count("count_ok", exp_ok, count_ok);
        check_count("count_trunc", exp_trunc, count_trunc);
        check_count("count_drop", exp_drop, count_drop);
        ready_mode = 1;
        clear_queues();
        @(posedge clk);
        rst <= 1'b0;
        repeat (3) @(posedge clk);
        send_frame(5, 1'b0);
        finish_test(5, "reset mid-frame", 1'b1);

        $display("5 tests run, %0d failed, %0d errors", tests_failed, errors);
        if (errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule
